/* include/datapath_config.svh */
// Sizes and address map shared by the datapath memory subsystem
// Include wherever a width, the RAM depth or the I/O window is needed

`ifndef DATAPATH_CONFIG_SVH
`define DATAPATH_CONFIG_SVH

// --------------------------------------------------
// Data word and address widths
// --------------------------------------------------

`define WORD_WIDTH          16
`define READ_ADDR_WIDTH     8

// Top bit of a write address selects bank A (0) or bank B (1)
`define WRITE_ADDR_WIDTH    9

// --------------------------------------------------
// Bank-local address map
// --------------------------------------------------

// Words 0 to 239 are RAM, 240 to 251 are unmapped
`define MEM_DEPTH           240

// Ports sit at 252 to 255, so the high 6 address bits are all ones
`define IO_PORT_COUNT       4
`define IO_PORT_BASE_ADDR   252
`define IO_PORT_SEL_WIDTH   2
`define IO_TAG_WIDTH        6

`endif

/* src/datapath_pkg.sv */
// Shared types for the datapath memory subsystem
// Modules refer to these by scoped name in their ports and import them in the body

`include "datapath_config.svh"

package datapath_pkg;

    // --------------------------------------------------
    // ALU operations
    // --------------------------------------------------

    typedef enum logic [2:0] {
        OP_ADD    = 3'd0,
        OP_SUB    = 3'd1,
        OP_AND    = 3'd2,
        OP_OR     = 3'd3,
        OP_XOR    = 3'd4,
        OP_PASS_A = 3'd5
    } alu_op_t;

    // --------------------------------------------------
    // Write address, read as RAM word or as I/O port
    // --------------------------------------------------

    typedef struct packed {
        logic                            bank_sel;
        logic [`WRITE_ADDR_WIDTH-2:0]    offset;
    } mem_addr_t;

    typedef struct packed {
        logic                            bank_sel;
        logic [`IO_TAG_WIDTH-1:0]        io_tag;
        logic [`IO_PORT_SEL_WIDTH-1:0]   port;
    } io_addr_t;

    typedef union packed {
        mem_addr_t mem;
        io_addr_t  io;
    } write_addr_t;

    // --------------------------------------------------
    // Pipeline payloads
    // --------------------------------------------------

    typedef struct packed {
        alu_op_t                         op;
        write_addr_t                     dest;
        logic [`READ_ADDR_WIDTH-1:0]     src_a;
        logic [`READ_ADDR_WIDTH-1:0]     src_b;
    } instr_t;

    typedef struct packed {
        logic                            valid;
        write_addr_t                     dest;
        logic [`WORD_WIDTH-1:0]          data;
    } wb_t;

    typedef struct packed {
        logic [`IO_PORT_COUNT-1:0]       wren;
        logic [`WORD_WIDTH-1:0]          data;
    } io_bus_t;

endpackage

/* src/memory_bank.sv */
// One data memory bank: RAM, I/O read ports and I/O write strobes
// Instantiated once per bank, with bank_index naming which write-backs it owns

`include "datapath_config.svh"

module memory_bank #(
    parameter bit bank_index = 1'b0
) (
    input  logic                                        clock,
    input  logic                                        rst_n,

    // Read side, driven from the issued instruction
    input  logic [`READ_ADDR_WIDTH-1:0]                 rd_addr,
    input  logic                                        rd_en,
    input  logic [`IO_PORT_COUNT-1:0][`WORD_WIDTH-1:0]  io_read_data,
    output logic [`WORD_WIDTH-1:0]                      rd_data,

    // Write side, shared write-back from the ALU
    input  datapath_pkg::wb_t                           wb,
    output datapath_pkg::io_bus_t                       io_out
);

    localparam logic [`READ_ADDR_WIDTH-1:0] ram_limit =
        `READ_ADDR_WIDTH'(`MEM_DEPTH);
    localparam logic [`IO_TAG_WIDTH-1:0] io_tag_value =
        `IO_TAG_WIDTH'(`IO_PORT_BASE_ADDR >> `IO_PORT_SEL_WIDTH);

    logic [`WORD_WIDTH-1:0] ram [0:`MEM_DEPTH-1];

    logic                              rd_is_ram;
    logic                              rd_is_io;
    logic [`IO_PORT_SEL_WIDTH-1:0]     rd_port;

    logic                              wr_owned;
    logic                              wr_is_ram;
    logic                              wr_is_io;
    logic [`IO_PORT_COUNT-1:0]         wr_wren;

    // --------------------------------------------------
    // Read address decode
    // --------------------------------------------------

    assign rd_is_ram = (rd_addr < ram_limit);
    assign rd_is_io  = (rd_addr[`READ_ADDR_WIDTH-1 -: `IO_TAG_WIDTH] == io_tag_value);
    assign rd_port   = rd_addr[`IO_PORT_SEL_WIDTH-1:0];

    // Synchronous read; I/O levels are sampled on the same edge
    always_ff @(posedge clock) begin
        if (rd_en) begin
            if (rd_is_ram) begin
                rd_data <= ram[rd_addr];
            end else if (rd_is_io) begin
                rd_data <= io_read_data[rd_port];
            end else begin
                // Unmapped reads return zero
                rd_data <= '0;
            end
        end
    end

    // --------------------------------------------------
    // Write address decode
    // --------------------------------------------------

    assign wr_owned  = wb.valid && (wb.dest.mem.bank_sel == bank_index);
    assign wr_is_ram = (wb.dest.mem.offset < ram_limit);
    assign wr_is_io  = (wb.dest.io.io_tag == io_tag_value);

    // One-hot strobe for the addressed port
    always_comb begin
        wr_wren = '0;
        wr_wren[wb.dest.io.port] = wr_owned && wr_is_io;
    end

    // Old data is read when a read and a write hit the same word
    always_ff @(posedge clock) begin
        if (wr_owned && wr_is_ram) begin
            ram[wb.dest.mem.offset] <= wb.data;
        end
    end

    // --------------------------------------------------
    // I/O write port
    // --------------------------------------------------

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            io_out.wren <= '0;
        end else begin
            io_out.wren <= wr_wren;
        end
        if (wr_owned && wr_is_io) begin
            io_out.data <= wb.data;
        end
    end

endmodule

/* src/datapath_alu.sv */
// Combines the two bank read words and registers the write-back
// Feeds both banks; the destination decides which one acts on it

`include "datapath_config.svh"

module datapath_alu (
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic                          op_valid,
    input  datapath_pkg::alu_op_t         op,
    input  datapath_pkg::write_addr_t     dest,
    input  logic [`WORD_WIDTH-1:0]        a,
    input  logic [`WORD_WIDTH-1:0]        b,
    output datapath_pkg::wb_t             wb
);

    import datapath_pkg::*;

    logic [`WORD_WIDTH-1:0] result;

    // --------------------------------------------------
    // Operation select
    // --------------------------------------------------

    // Add and subtract wrap at the word width
    always_comb begin
        case (op)
            OP_ADD:  result = a + b;
            OP_SUB:  result = a - b;
            OP_AND:  result = a & b;
            OP_OR:   result = a | b;
            OP_XOR:  result = a ^ b;
            OP_PASS_A: result = a;
            // Unused encodings behave as pass
            default: result = a;
        endcase
    end

    // --------------------------------------------------
    // Write-back register
    // --------------------------------------------------

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= op_valid;
        end
        wb.dest <= dest;
        wb.data <= result;
    end

endmodule

/* src/datapath_top.sv */
// Top of the data-memory subsystem: two banks side by side and one ALU
// Takes one instruction per cycle; an I/O strobe follows 3 cycles after issue

`include "datapath_config.svh"

module datapath_top (
    input  logic                                        clock,
    input  logic                                        rst_n,

    // Issued instruction, already address translated
    input  logic                                        instr_valid,
    input  datapath_pkg::instr_t                        instr,

    // I/O read levels from the outside world
    input  logic [`IO_PORT_COUNT-1:0][`WORD_WIDTH-1:0]  io_read_data_a,
    input  logic [`IO_PORT_COUNT-1:0][`WORD_WIDTH-1:0]  io_read_data_b,

    // I/O write strobes to the outside world
    output datapath_pkg::io_bus_t                       io_out_a,
    output datapath_pkg::io_bus_t                       io_out_b
);

    import datapath_pkg::*;

    instr_t                    instr_q;
    logic                      instr_valid_q;

    // Stage 2 control, lined up with the bank read data
    alu_op_t                   op_s2;
    write_addr_t               dest_s2;
    logic                      valid_s2;

    logic [`WORD_WIDTH-1:0]    rd_data_a;
    logic [`WORD_WIDTH-1:0]    rd_data_b;
    wb_t                       wb;

    // --------------------------------------------------
    // Issue and control pipeline
    // --------------------------------------------------

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            instr_valid_q <= 1'b0;
            valid_s2      <= 1'b0;
        end else begin
            instr_valid_q <= instr_valid;
            valid_s2      <= instr_valid_q;
        end
        if (instr_valid) begin
            instr_q <= instr;
        end
        op_s2   <= instr_q.op;
        dest_s2 <= instr_q.dest;
    end

    // --------------------------------------------------
    // Banks and ALU
    // --------------------------------------------------

    memory_bank #(
        .bank_index     (1'b0)
    ) bank_a (
        .clock          (clock),
        .rst_n          (rst_n),
        .rd_addr        (instr_q.src_a),
        .rd_en          (instr_valid_q),
        .io_read_data   (io_read_data_a),
        .rd_data        (rd_data_a),
        .wb             (wb),
        .io_out         (io_out_a)
    );

    memory_bank #(
        .bank_index     (1'b1)
    ) bank_b (
        .clock          (clock),
        .rst_n          (rst_n),
        .rd_addr        (instr_q.src_b),
        .rd_en          (instr_valid_q),
        .io_read_data   (io_read_data_b),
        .rd_data        (rd_data_b),
        .wb             (wb),
        .io_out         (io_out_b)
    );

    datapath_alu alu0 (
        .clock          (clock),
        .rst_n          (rst_n),
        .op_valid       (valid_s2),
        .op             (op_s2),
        .dest           (dest_s2),
        .a              (rd_data_a),
        .b              (rd_data_b),
        .wb             (wb)
    );

endmodule

/* sim/tb_clock_gen.sv */
// Clock and reset source for the datapath testbench
// 100 ns clock, synchronous active-low reset held for 8 rising edges

module tb_clock_gen (
    output logic clock,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // Released just after the eighth edge, like any other driven input
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clock);
        #10 rst_n = 1'b1;
    end

endmodule

/* sim/datapath_tb.sv */
// Table-driven testbench for the datapath memory subsystem
// Rows are issued in order; a reference model predicts each I/O write strobe

`include "datapath_config.svh"

module datapath_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import datapath_pkg::*;

    localparam int CLOCK_PERIOD = 100;
    localparam int DRIVE_DELAY  = 10;
    localparam int RESET_CYCLES = 8;
    localparam int QUIET_CYCLES = 10;
    localparam int MAX_ROWS     = 24;
    localparam int NO_STROBE    = -1;
    localparam int WORD_RANGE   = 1 << `WORD_WIDTH;

    // Pending RAM write or expected strobe; addr holds the port for a strobe
    typedef struct packed {
        logic [31:0]            due;
        logic [31:0]            row;
        logic                   bank;
        logic [7:0]             addr;
        logic [`WORD_WIDTH-1:0] data;
    } model_event_t;

    logic                                         clock;
    logic                                         rst_n;
    logic                                         instr_valid;
    instr_t                                       instr;
    logic [`IO_PORT_COUNT-1:0][`WORD_WIDTH-1:0]   io_read_data_a;
    logic [`IO_PORT_COUNT-1:0][`WORD_WIDTH-1:0]   io_read_data_b;
    io_bus_t                                      io_out_a;
    io_bus_t                                      io_out_b;

    instr_t                 row_instr [MAX_ROWS];
    int                     row_idle  [MAX_ROWS];
    int                     row_out   [MAX_ROWS];
    string                  row_name  [MAX_ROWS];
    int                     row_count;
    int                     watchdog_cycles;

    logic [`WORD_WIDTH-1:0] model_ram [2][`MEM_DEPTH];
    model_event_t           pend_q[$];
    model_event_t           exp_q[$];

    int                     edge_count = 0;
    bit                     monitor_on;
    bit                     table_ready;
    integer                 seed;

    tb_clock_gen clock_gen0 (
        .clock          (clock),
        .rst_n          (rst_n)
    );

    datapath_top dut0 (
        .clock          (clock),
        .rst_n          (rst_n),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .io_read_data_a (io_read_data_a),
        .io_read_data_b (io_read_data_b),
        .io_out_a       (io_out_a),
        .io_out_b       (io_out_b)
    );

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic report_mismatch(input int row, input string field,
                                   input int expected, input int actual);
        abort_run($sformatf("[ERROR] %s: %s expected 0x%0h, actual 0x%0h",
                            row_name[row], field, expected, actual));
    endtask

    function automatic write_addr_t ram_dest(input bit bank, input int offset);
        write_addr_t d;
        d.mem.bank_sel = bank;
        d.mem.offset   = offset[`READ_ADDR_WIDTH-1:0];
        return d;
    endfunction

    // I/O window tag is all ones (63)
    function automatic write_addr_t io_dest(input bit bank, input int port);
        write_addr_t d;
        d.io.bank_sel = bank;
        d.io.io_tag   = '1;
        d.io.port     = port[`IO_PORT_SEL_WIDTH-1:0];
        return d;
    endfunction

    function automatic int port_code(input int bank, input int port);
        return bank * `IO_PORT_COUNT + port;
    endfunction

    task automatic add_row(input string name, input alu_op_t op, input write_addr_t dest,
                           input logic [7:0] src_a, input logic [7:0] src_b,
                           input int idle, input int out);
        instr_t entry;
        entry.op    = op;
        entry.dest  = dest;
        entry.src_a = src_a;
        entry.src_b = src_b;
        row_instr[row_count] = entry;
        row_name[row_count]  = name;
        row_idle[row_count]  = idle;
        row_out[row_count]   = out;
        row_count++;
    endtask

    task automatic build_table();
        int i;
        row_count = 0;
        // I/O words into RAM; bank B words go through an OR with an unmapped zero
        add_row("load_a_port0", OP_PASS_A, ram_dest(0, 10), 8'd252, 8'd0, 0, NO_STROBE);
        add_row("load_a_port1", OP_PASS_A, ram_dest(0, 11), 8'd253, 8'd0, 0, NO_STROBE);
        add_row("load_b_port2", OP_OR, ram_dest(1, 20), 8'd240, 8'd254, 0, NO_STROBE);
        add_row("load_b_port3", OP_OR, ram_dest(1, 21), 8'd241, 8'd255, 2, NO_STROBE);
        // Read back, then every opcode issued back to back
        add_row("readback_a", OP_PASS_A, io_dest(0, 0), 8'd10, 8'd0, 0, port_code(0, 0));
        add_row("readback_b", OP_OR, io_dest(1, 1), 8'd250, 8'd20, 0, port_code(1, 1));
        add_row("op_add", OP_ADD, io_dest(0, 2), 8'd10, 8'd20, 0, port_code(0, 2));
        add_row("op_sub", OP_SUB, io_dest(0, 3), 8'd11, 8'd21, 0, port_code(0, 3));
        add_row("op_and", OP_AND, io_dest(1, 0), 8'd10, 8'd21, 0, port_code(1, 0));
        add_row("op_or", OP_OR, io_dest(1, 1), 8'd11, 8'd20, 0, port_code(1, 1));
        add_row("op_xor", OP_XOR, io_dest(1, 2), 8'd10, 8'd20, 0, port_code(1, 2));
        add_row("op_pass_a", OP_PASS_A, io_dest(1, 3), 8'd11, 8'd21, 0, port_code(1, 3));
        // Unmapped reads give zero, unmapped writes vanish
        add_row("unmapped_read", OP_ADD, io_dest(0, 1), 8'd245, 8'd248, 0, port_code(0, 1));
        add_row("unmapped_wr_a", OP_PASS_A, ram_dest(0, 250), 8'd252, 8'd0, 0, NO_STROBE);
        add_row("unmapped_wr_b", OP_OR, ram_dest(1, 246), 8'd240, 8'd253, 2, NO_STROBE);
        add_row("unmapped_check", OP_XOR, io_dest(0, 1), 8'd11, 8'd20, 0, port_code(0, 1));
        // Store at the minimum gap, then read back into a bank B port
        add_row("store_sum", OP_ADD, ram_dest(0, 30), 8'd10, 8'd21, 2, NO_STROBE);
        add_row("readback_sum", OP_PASS_A, io_dest(1, 0), 8'd30, 8'd0, 0, port_code(1, 0));
        add_row("sub_wrap", OP_SUB, io_dest(0, 3), 8'd240, 8'd21, 3, port_code(0, 3));

        watchdog_cycles = row_count + RESET_CYCLES + QUIET_CYCLES + 20;
        for (i = 0; i < row_count; i++) begin
            watchdog_cycles += row_idle[i];
        end
    endtask

    function automatic logic [`WORD_WIDTH-1:0] model_read(input int bank, input int addr);
        if (addr < `MEM_DEPTH) begin
            return model_ram[bank][addr];
        end else if (addr >= `IO_PORT_BASE_ADDR) begin
            return (bank == 0) ? io_read_data_a[addr - `IO_PORT_BASE_ADDR]
                               : io_read_data_b[addr - `IO_PORT_BASE_ADDR];
        end else begin
            return '0;
        end
    endfunction

    function automatic logic [`WORD_WIDTH-1:0] alu_result(input alu_op_t op,
            input logic [`WORD_WIDTH-1:0] a, input logic [`WORD_WIDTH-1:0] b);
        int full;
        case (op)
            OP_ADD:  full = int'(a) + int'(b);
            OP_SUB:  full = int'(a) - int'(b) + WORD_RANGE;
            OP_AND:  full = int'(a & b);
            OP_OR:   full = int'(a | b);
            OP_XOR:  full = int'(a ^ b);
            default: full = int'(a);
        endcase
        return full % WORD_RANGE;
    endfunction

    // Called just after an edge; the instruction is sampled at the next one
    task automatic issue_row(input int i);
        int           k;
        model_event_t ev;
        k = edge_count + 1;
        // Reads at edge k+1 see writes done at edge k or earlier
        while (pend_q.size() > 0 && pend_q[0].due <= k) begin
            model_ram[pend_q[0].bank][pend_q[0].addr] = pend_q[0].data;
            void'(pend_q.pop_front());
        end
        ev.due  = k + 3;
        ev.row  = i;
        ev.data = alu_result(row_instr[i].op, model_read(0, row_instr[i].src_a),
                             model_read(1, row_instr[i].src_b));
        if (row_instr[i].dest.mem.offset < `MEM_DEPTH) begin
            ev.bank = row_instr[i].dest.mem.bank_sel;
            ev.addr = row_instr[i].dest.mem.offset;
            pend_q.push_back(ev);
        end
        if (row_out[i] != NO_STROBE) begin
            ev.bank = row_out[i] / `IO_PORT_COUNT;
            ev.addr = row_out[i] % `IO_PORT_COUNT;
            exp_q.push_back(ev);
        end
        instr       = row_instr[i];
        instr_valid = 1'b1;
    endtask

    task automatic check_outputs();
        model_event_t              ev;
        logic [`IO_PORT_COUNT-1:0] wren;
        logic [`WORD_WIDTH-1:0]    data;
        logic                      bank;
        bit                        due_now;
        due_now = (exp_q.size() > 0) && (exp_q[0].due == edge_count);
        if (io_out_a.wren == '0 && io_out_b.wren == '0) begin
            assert (!due_now) else abort_run($sformatf(
                "No I/O strobe appeared for test %s at edge %0d",
                row_name[exp_q[0].row], edge_count));
        end else begin
            assert (io_out_a.wren == '0 || io_out_b.wren == '0)
                else abort_run("Both banks strobed an I/O port in the same cycle");
            bank = (io_out_a.wren == '0);
            wren = bank ? io_out_b.wren : io_out_a.wren;
            data = bank ? io_out_b.data : io_out_a.data;
            assert ($onehot(wren)) else abort_run($sformatf(
                "More than one wren bit is set on bank %0d (%b)", bank, wren));
            assert (due_now) else abort_run($sformatf(
                "Strobe on bank %0d at edge %0d matches no issued instruction",
                bank, edge_count));
            ev = exp_q.pop_front();
            assert (bank == ev.bank) else report_mismatch(ev.row, "bank", ev.bank, bank);
            assert (wren == (1 << ev.addr))
                else report_mismatch(ev.row, "wren", 1 << ev.addr, wren);
            assert (data == ev.data) else report_mismatch(ev.row, "data", ev.data, data);
        end
    endtask

    // --------------------------------------------------
    // Edge counter, monitor and watchdog
    // --------------------------------------------------

    always @(posedge clock) begin
        edge_count <= edge_count + 1;
    end

    // Outputs are stable half a cycle after the edge that set them
    always @(negedge clock) begin
        if (monitor_on) begin
            check_outputs();
        end
    end

    initial begin
        wait (table_ready);
        #(watchdog_cycles * CLOCK_PERIOD);
        abort_run("Watchdog timeout: the testbench did not reach its end in time");
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------

    initial begin
        int i;
        int p;
        instr_valid = 1'b0;
        instr       = '0;
        seed        = 32'haa5c;
        for (p = 0; p < `IO_PORT_COUNT; p++) begin
            io_read_data_a[p] = `WORD_WIDTH'($random(seed));
            io_read_data_b[p] = `WORD_WIDTH'($random(seed));
        end
        build_table();
        table_ready = 1'b1;

        wait (rst_n === 1'b1);
        monitor_on = 1'b1;
        // Quiet period, no strobe allowed
        repeat (QUIET_CYCLES) @(posedge clock);
        #DRIVE_DELAY;
        for (i = 0; i < row_count; i++) begin
            issue_row(i);
            @(posedge clock);
            #DRIVE_DELAY;
            instr_valid = 1'b0;
            repeat (row_idle[i]) begin
                @(posedge clock);
                #DRIVE_DELAY;
            end
        end
        repeat (6) @(posedge clock);
        @(negedge clock);

        if (exp_q.size() == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            abort_run($sformatf("%0d expected strobes never appeared", exp_q.size()));
        end
    end

endmodule

/* flist.f */
+incdir+include
src/datapath_pkg.sv
src/memory_bank.sv
src/datapath_alu.sv
src/datapath_top.sv
sim/tb_clock_gen.sv
sim/datapath_tb.sv
